/* audio_out_chk.sv */
//==========================================================================
// I2S clock checker
// Concurrent assertions on the divider clocks and the frame strobe
//==========================================================================
`timescale 1ns/1ps

module audio_out_chk
(
    input logic clk,
    input logic reset,
    input logic mclk,
    input logic bclk,
    input logic lrclk,
    input logic frame_strobe
);

    logic       mclk_d;       // Clocks one cycle back, for edge detection
    logic       bclk_d;
    logic       lrclk_d;
    logic       strobe_d;
    logic [3:0] mclk_rises;   // MCLK rising edges since the last BCLK rise
    logic       bclk_seen;    // A full BCLK period has been counted
    logic       mclk_rise;
    logic       bclk_rise;

    assign mclk_rise = mclk && !mclk_d;
    assign bclk_rise = bclk && !bclk_d;  // Never lands on an MCLK rise with this divider

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mclk_d     <= 1'b0;
            bclk_d     <= 1'b0;
            lrclk_d    <= 1'b0;
            strobe_d   <= 1'b0;
            mclk_rises <= '0;
            bclk_seen  <= 1'b0;
        end
        else
        begin
            mclk_d   <= mclk;
            bclk_d   <= bclk;
            lrclk_d  <= lrclk;
            strobe_d <= frame_strobe;
            if (bclk_rise)
            begin
                mclk_rises <= '0;     // Start counting the next BCLK period
                bclk_seen  <= 1'b1;
            end
            else if (mclk_rise)
                mclk_rises <= mclk_rises + 1'b1;
        end
    end

    // Word select moves only in the low half of BCLK
    assert property (@(posedge clk) disable iff (reset) (lrclk != lrclk_d) |-> !bclk)
        else $error("LRCLK changed while BCLK was high");

    // The strobe sits on the last clock of a frame, so LRCLK falls on the next one
    assert property (@(posedge clk) disable iff (reset) strobe_d == (lrclk_d && !lrclk))
        else $error("Frame strobe is not on the clock before the LRCLK falling edge");

    // One clock wide, so it falls right after the count of all ones
    assert property (@(posedge clk) disable iff (reset) strobe_d |-> !frame_strobe)
        else $error("Frame strobe lasted longer than one clock");

    assert property (@(posedge clk) disable iff (reset)
                     (bclk_rise && bclk_seen) |-> (mclk_rises == 4'd4))
        else $error("MCLK is not four times the BCLK frequency");

endmodule

bind i2s_audio_out audio_out_chk u_chk
(
    .clk          (clk),
    .reset        (reset),
    .mclk         (mclk),
    .bclk         (bclk),
    .lrclk        (lrclk),
    .frame_strobe (frame_strobe)
);

/* audio_out_top.sv */
//==========================================================================
// Test-tone source top level
// Feeds the square-wave generator into the I2S transmitter
//==========================================================================
`timescale 1ns/1ps

module audio_out_top
(
    input  logic               clk,     // 50 MHz system clock
    input  logic               reset,   // Asynchronous and active high
    input  audio_pkg::note_t   note,    // Semitone 0 to 11 from C
    input  audio_pkg::octave_t octave,  // Octave 0 to 3 above the table
    input  logic               enable,  // Low mutes the tone
    output logic               mclk,    // DAC master clock at clk / 4
    output logic               bclk,    // Bit clock at clk / 16
    output logic               lrclk,   // Word select at clk / 1024
    output logic               sdata    // Serial audio data
);

    // The current tone sample, held for a whole frame
    audio_pkg::sample_t sample;

    // Frame boundary pulse from the transmitter
    logic               frame_strobe;

    // The generator steps once per frame so its sample rate matches LRCLK
    tone_generator u_tone
    (
        .clk          (clk),
        .reset        (reset),
        .frame_strobe (frame_strobe),
        .note         (note),
        .octave       (octave),
        .enable       (enable),
        .sample       (sample)
    );

    // The transmitter owns the divider and tells the generator when a frame ends
    // A sample made at the end of one frame is heard in the next one
    i2s_audio_out u_i2s
    (
        .clk          (clk),
        .reset        (reset),
        .data_in      (sample),
        .mclk         (mclk),
        .bclk         (bclk),
        .lrclk        (lrclk),
        .sdata        (sdata),
        .frame_strobe (frame_strobe)
    );

endmodule

/* audio_pkg.sv */
//==========================================================================
// Audio package for the I2S test-tone source
// Holds clock division constants, sample format and shared types
//==========================================================================
package audio_pkg;

    // System clock rate in MHz
    localparam int CLK_MHZ = 50;

    // Divider bit positions for the 256:64:1 ratio of MCLK, BCLK and LRCLK
    // Each clock is the MSB of a slice of one binary counter
    localparam int MCLK_BIT  = $clog2(CLK_MHZ) - 4;  // Gives 2 at 50 MHz so MCLK is clk / 4
    localparam int BCLK_BIT  = MCLK_BIT + 2;         // BCLK is clk / 16
    localparam int LRCLK_BIT = BCLK_BIT + 6;         // One frame spans 1024 system clocks

    localparam int SLOT_W   = 32;  // Bits in one channel slot
    localparam int SAMPLE_W = 16;  // Audio sample resolution

    // Position of the sample inside its slot
    // Standard I2S wants it left-aligned behind the one-bit delay
    localparam bit ALIGN_RIGHT = 1'b0;

    // Twelve semitones per octave in the tone table
    localparam int NOTE_COUNT = 12;

    typedef logic signed [SAMPLE_W - 1:0] sample_t;       // Two's-complement audio sample
    typedef logic        [3:0]            note_t;         // Semitone index from C upwards
    typedef logic        [1:0]            octave_t;       // Right shift applied to half period
    typedef logic        [11:0]           half_period_t;  // Length of a half wave in frames
    typedef logic        [LRCLK_BIT - 1:0] div_t;         // Free-running clock divider count

    // Highest valid note, larger indices are clamped to it
    localparam note_t NOTE_LAST = note_t'(NOTE_COUNT - 1);

    // Square-wave magnitude, about a quarter of full scale
    localparam sample_t AMPLITUDE = sample_t'(16'sh2000);

endpackage

/* files.f */
+incdir+.
audio_pkg.sv
tone_generator.sv
i2s_audio_out.sv
audio_out_top.sv
audio_out_chk.sv
tb_audio_out.sv

/* i2s_audio_out.sv */
//==========================================================================
// I2S transmitter for PCM5102A-class DACs
// Divides the system clock into MCLK, BCLK and LRCLK and shifts the sample
// out MSB first in both 32-bit slots of each frame
//==========================================================================
`timescale 1ns/1ps

module i2s_audio_out
(
    input  logic               clk,
    input  logic               reset,
    input  audio_pkg::sample_t data_in,
    output logic               mclk,
    output logic               bclk,
    output logic               lrclk,         // Low for left and high for right
    output logic               sdata,
    output logic               frame_strobe   // High on the last clock of a frame
);

    audio_pkg::div_t                clk_div;    // Free-running divider
    logic [audio_pkg::SLOT_W - 1:0] shift;      // Output shift register
    logic [audio_pkg::SLOT_W - 1:0] load_word;  // Sample placed inside its slot
    logic                           bclk_fall;  // Last clock before BCLK goes low
    logic                           slot_load;  // End of the first BCLK period of a slot

    // Every clock is one bit of the same counter so their phases stay locked
    assign mclk  = clk_div[audio_pkg::MCLK_BIT - 1];
    assign bclk  = clk_div[audio_pkg::BCLK_BIT - 1];
    assign lrclk = clk_div[audio_pkg::LRCLK_BIT - 1];

    assign sdata = shift[audio_pkg::SLOT_W - 1];  // MSB leads

    assign frame_strobe = &clk_div;  // Count 1023 closes the right slot

    // The low BCLK bits all ones mark the clock before the falling BCLK edge
    assign bclk_fall = &clk_div[audio_pkg::BCLK_BIT - 1:0];

    // The slot position bits above BCLK are zero during the first BCLK period
    // Loading at its end delays the MSB by one bit as I2S requires
    assign slot_load = bclk_fall &&
                       (clk_div[audio_pkg::LRCLK_BIT - 2:audio_pkg::BCLK_BIT] == '0);

    always_comb
    begin
        if (audio_pkg::ALIGN_RIGHT)
            load_word = {{(audio_pkg::SLOT_W - audio_pkg::SAMPLE_W - 1){1'b0}}, data_in, 1'b0};
        else
            load_word = {data_in, {(audio_pkg::SLOT_W - audio_pkg::SAMPLE_W){1'b0}}};
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            clk_div <= '0;
        else
            clk_div <= clk_div + 1'b1;  // Wraps once per frame
    end

    // Shifting on the falling BCLK edge keeps sdata stable at the rising edge
    // where the DAC samples it
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shift <= '0;  // Keeps sdata low out of reset
        else if (slot_load)
            shift <= load_word;  // Same sample goes into the left and right slots
        else if (bclk_fall)
            shift <= shift << 1;  // Zeros fill the slot after the sample bits
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile the test-tone testbench with Verilator and run it
# The run passes only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_audio_out -f files.f -o sim_audio_out \
    && ./obj_dir/sim_audio_out | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && echo "run_sim: tone testbench passed" \
    || { echo "run_sim: tone testbench failed"; exit 1; }

/* tb_audio_out.sv */
//==========================================================================
// Testbench for the I2S test-tone source
// Plays the tone trace, decodes the serial stream and checks every frame
//==========================================================================
`timescale 1ns/1ps

module tb_audio_out;

    localparam int CLK_PERIOD_NS = 40;
    localparam int FRAME_CLOCKS  = 1024;  // System clocks in one LRCLK period
    localparam int RESET_CYCLES  = 8;
    localparam int SLOT_BITS     = 32;
    localparam int MAX_LINES     = 64;

    logic               clk;
    logic               reset;
    audio_pkg::note_t   note;
    audio_pkg::octave_t octave;
    logic               enable;
    logic               mclk;
    logic               bclk;
    logic               lrclk;
    logic               sdata;

    // Trace rows, one entry per stimulus line
    int trace_note   [MAX_LINES];
    int trace_oct    [MAX_LINES];
    int trace_en     [MAX_LINES];
    int trace_frames [MAX_LINES];
    int trace_half   [MAX_LINES];
    int line_count;
    int total_frames;
    bit trace_loaded;

    int value_errors;
    int setup_errors;    // Trace or sequencing problems
    int frames_checked;

    // Square-wave reference model
    string test_name;
    int    model_half;
    bit    model_en;
    int    model_cnt;    // Frames sent in the current run
    bit    model_neg;
    int    skip_frames;  // Frames still carrying the previous sample
    bit    model_active;
    int    frame_no;

    // Serial decoder state
    bit          prev_lr;
    int          bit_idx;
    logic [15:0] shift_word;
    logic [15:0] word_l;
    logic [15:0] word_r;
    bit          tail_set;   // A one was seen after the 16 sample bits

    audio_out_top u_dut
    (
        .clk    (clk),
        .reset  (reset),
        .note   (note),
        .octave (octave),
        .enable (enable),
        .mclk   (mclk),
        .bclk   (bclk),
        .lrclk  (lrclk),
        .sdata  (sdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    task automatic read_trace();
        int    fd;
        int    n;
        int    line_no;
        int    t_note, t_oct, t_en, t_frames, t_half;
        string line;
        fd = $fopen("tone_trace.txt", "r");
        line_count = 0;
        line_no    = 0;
        if (fd == 0)
        begin
            $display("Cannot open tone_trace.txt");
            setup_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                // Comment lines start with a hash, blank lines are passed over
                if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23)
                begin
                    n = $sscanf(line, "%d %d %d %d %d", t_note, t_oct, t_en, t_frames, t_half);
                    if (n != 5 || line_count >= MAX_LINES || t_half < 1 || t_frames < 2)
                    begin
                        $display("Trace line %0d cannot be used as stimulus", line_no);
                        setup_errors++;
                    end
                    else
                    begin
                        trace_note[line_count]   = t_note;
                        trace_oct[line_count]    = t_oct;
                        trace_en[line_count]     = t_en;
                        trace_frames[line_count] = t_frames;
                        trace_half[line_count]   = t_half;
                        line_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Every row starts a fresh run, positive and at count zero
    task automatic apply_line(input int i);
        note         = audio_pkg::note_t'(trace_note[i]);
        octave       = audio_pkg::octave_t'(trace_oct[i]);
        enable       = (trace_en[i] != 0);
        test_name    = $sformatf("line%0d_note%0d_oct%0d_en%0d", i, trace_note[i],
                                 trace_oct[i], trace_en[i]);
        model_half   = trace_half[i];
        model_en     = (trace_en[i] != 0);
        model_cnt    = 0;
        model_neg    = 1'b0;
        skip_frames  = 1;  // The next decoded frame still holds the old sample
        model_active = 1'b1;
    endtask

    task automatic check_reset_pins(input string name);
        logic [3:0] pins;
        pins = {mclk, bclk, lrclk, sdata};
        assert (pins == 4'b0000)
        else
        begin
            value_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, 4'b0000, pins);
        end
    endtask

    task automatic compare_word(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        assert (actual == expected)
        else
        begin
            value_errors++;
            $display("CHECK FAILED %s frame %0d: expected %h, actual %h",
                     name, frame_no, expected, actual);
        end
    endtask

    task automatic check_frame();
        logic [15:0] expected;
        compare_word({test_name, "_right_vs_left"}, word_l, word_r);
        if (frame_no == 0)
            compare_word("reset_frame", 16'h0000, word_r);  // Sample still at its reset value
        else if (skip_frames > 0)
            skip_frames--;
        else if (model_active)
        begin
            if (!model_en)
                expected = '0;
            else
                expected = model_neg ? -audio_pkg::AMPLITUDE : audio_pkg::AMPLITUDE;
            compare_word(test_name, expected, word_r);
            frames_checked++;
            if (model_en)
            begin
                if (model_cnt == model_half - 1)  // Run complete, flip the polarity
                begin
                    model_neg = !model_neg;
                    model_cnt = 0;
                end
                else
                    model_cnt++;
            end
        end
        frame_no++;
    endtask

    task automatic finish_slot();
        assert (!tail_set)
        else
        begin
            value_errors++;
            $display("CHECK FAILED %s frame %0d slot %0d tail bits: expected %b, actual %b",
                     test_name, frame_no, lrclk, 1'b0, 1'b1);
        end
        if (!lrclk)
            word_l = shift_word;
        else
        begin
            word_r = shift_word;
            check_frame();  // Right slot closes the frame
        end
    endtask

    // The DAC view: bits are taken on the BCLK rising edge
    initial
    begin : decoder
        prev_lr  = 1'b1;  // Makes the first rise after reset open a left slot
        bit_idx  = 0;
        tail_set = 1'b0;
        forever
        begin
            @(posedge bclk);
            if (lrclk != prev_lr)
                bit_idx = 0;
            else
                bit_idx++;
            prev_lr = lrclk;
            if (bit_idx == 0)
                tail_set = 1'b0;  // I2S delay bit, not part of the word
            else if (bit_idx <= audio_pkg::SAMPLE_W)
                shift_word = {shift_word[14:0], sdata};  // MSB arrives first
            else
                tail_set = tail_set | sdata;
            if (bit_idx == SLOT_BITS - 1)
                finish_slot();
        end
    end

    initial
    begin : watchdog
        longint limit_ns;
        wait (trace_loaded);
        limit_ns = (longint'(total_frames) + 4) * FRAME_CLOCKS * CLK_PERIOD_NS;
        #(limit_ns);
        $display("Timeout: the tone trace did not finish within %0d ns", limit_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin : stimulus
        int i;
        reset          = 1'b1;
        note           = '0;
        octave         = '0;
        enable         = 1'b0;
        value_errors   = 0;
        setup_errors   = 0;
        frames_checked = 0;
        frame_no       = 0;
        skip_frames    = 0;
        model_active   = 1'b0;
        test_name      = "idle";
        read_trace();
        total_frames = 0;
        for (i = 0; i < line_count; i++)
            total_frames += trace_frames[i];
        trace_loaded = 1'b1;
        if (line_count == 0)
        begin
            $display("The tone trace holds no stimulus rows");
            setup_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_reset_pins("reset_hold");
        reset = 1'b0;
        check_reset_pins("reset_release");

        @(negedge lrclk);  // First frame carries the reset sample
        for (i = 0; i < line_count; i++)
        begin
            @(negedge clk);
            apply_line(i);
            repeat (trace_frames[i]) @(negedge lrclk);
        end

        assert (frames_checked > 0)
        else
        begin
            setup_errors++;
            $display("No decoded frame was compared with the reference model");
        end
        $display("Errors: %0d value, %0d setup, frames checked %0d",
                 value_errors, setup_errors, frames_checked);
        if (value_errors == 0 && setup_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tone_generator.sv */
//==========================================================================
// Square-wave tone generator
// Advances once per audio frame and holds its sample between strobes
//==========================================================================
`timescale 1ns/1ps

module tone_generator
(
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_strobe,  // One pulse at the end of each frame
    input  audio_pkg::note_t   note,
    input  audio_pkg::octave_t octave,
    input  logic               enable,
    output audio_pkg::sample_t sample
);

    `include "tone_table.svh"

    // Registered state, updated only on the frame strobe
    audio_pkg::note_t        note_q;      // Note seen at the previous strobe
    audio_pkg::octave_t      octave_q;    // Octave seen at the previous strobe
    audio_pkg::half_period_t frame_cnt;   // Frames already sent in the current run
    logic                    negative;    // Polarity of the current run

    // Combinational view of the next step
    audio_pkg::note_t        note_idx;
    audio_pkg::half_period_t half_period;
    audio_pkg::half_period_t cnt_eff;
    logic                    neg_eff;
    logic                    restart;

    always_comb
    begin
        // Notes above B fall back to B so the table index stays in range
        note_idx = (note > audio_pkg::NOTE_LAST) ? audio_pkg::NOTE_LAST : note;

        // Each octave up halves the run length
        half_period = TONE_HALF_PERIOD[note_idx] >> octave;

        // A new note or octave starts over with a fresh positive run
        restart = (note != note_q) || (octave != octave_q);
        cnt_eff = restart ? '0 : frame_cnt;
        neg_eff = restart ? 1'b0 : negative;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            note_q    <= '0;
            octave_q  <= '0;
            frame_cnt <= '0;
            negative  <= 1'b0;
            sample    <= '0;  // Silence until the first strobe
        end
        else if (frame_strobe)
        begin
            note_q   <= note;    // Remember the inputs to spot a change next frame
            octave_q <= octave;

            if (!enable)
            begin
                // Muted output parks the wave at the start of a positive run
                frame_cnt <= '0;
                negative  <= 1'b0;
                sample    <= '0;
            end
            else
            begin
                sample <= neg_eff ? -audio_pkg::AMPLITUDE : audio_pkg::AMPLITUDE;

                if (cnt_eff == half_period - 1'b1)  // Last frame of this half wave
                begin
                    negative  <= ~neg_eff;
                    frame_cnt <= '0;
                end
                else
                begin
                    negative  <= neg_eff;
                    frame_cnt <= cnt_eff + 1'b1;
                end
            end
        end
    end

endmodule

/* tone_table.svh */
//==========================================================================
// Half-period table for the square-wave tone source
// Lowest octave from C3 to B3, in audio frames
//==========================================================================
`ifndef TONE_TABLE_SVH
`define TONE_TABLE_SVH

// The frame rate is 50 MHz / 1024 which is about 48828 Hz
// Each entry is the frame rate divided by twice the note frequency
// Values are rounded to the nearest whole frame
// Higher octaves shift these counts right by the octave number

localparam audio_pkg::half_period_t TONE_HALF_PERIOD [audio_pkg::NOTE_COUNT] = '{
    12'd187,  // C   130.81 Hz
    12'd176,  // C#  138.59 Hz
    12'd166,  // D   146.83 Hz
    12'd157,  // D#  155.56 Hz
    12'd148,  // E   164.81 Hz
    12'd140,  // F   174.61 Hz
    12'd132,  // F#  185.00 Hz
    12'd125,  // G   196.00 Hz
    12'd118,  // G#  207.65 Hz
    12'd111,  // A   220.00 Hz
    12'd105,  // A#  233.08 Hz
    12'd99    // B   246.94 Hz
};

// The shortest run is B at octave 3 with 12 frames per half wave
// so a half period never collapses to zero

`endif

/* tone_trace.txt */
# Columns: note (0-11 from C), octave (0-3), enable, frames to run, expected half period
# Every row restarts the wave through a note, octave or enable change
# Octave 0 runs, long enough for several polarity flips
0 0 1 400 187
# Note change in the middle of a positive run
9 0 1 240 111
# Octaves 1 to 3 halve the run each step
9 1 1 130 55
9 2 1 70 27
9 3 1 40 13
# Mute, then enable again with the same note
9 3 0 30 13
9 3 1 40 13
11 3 1 40 12
# Mute while the note changes
4 0 0 20 148
4 0 1 320 148
2 2 1 100 41
7 1 1 150 62
5 3 1 60 17
0 0 0 10 187
# More notes across the octaves
1 1 1 200 88
3 0 1 330 157
6 2 1 80 33
8 3 1 50 14
10 1 1 120 52
10 1 0 15 52
10 1 1 110 52
11 0 1 210 99
0 3 1 50 23
